// File: i2c_master_top.f
src/i2c_pkg.sv
src/i2c_bit_ctrl.sv
src/i2c_byte_ctrl.sv
src/i2c_master_top.sv
sim/tb_clock_gen.sv
sim/i2c_slave_model.sv
sim/tb_checker.sv
sim/tb_i2c_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the I2C master testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_i2c_master \
    --Mdir obj_dir -o Vtb_i2c_master \
    -f i2c_master_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_i2c_master > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

grep -q "^test passed$" "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $LOG"
    exit 1
fi

exit 0

// File: sim/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] SLAVE_ADDR = 7'h00
) (
    input  logic scl,
    input  logic sda,
    output logic sda_oe
);

    typedef enum {S_IDLE, S_ADDR, S_WR, S_RD, S_SKIP} slave_mode_t;

    slave_mode_t mode      = S_IDLE;
    logic [7:0]  mem_q     = 8'h00;
    logic [7:0]  sr        = 8'h00;
    int          bit_idx   = 0;
    logic        rose      = 1'b0;
    logic        nack      = 1'b0;
    logic        scl_q     = 1'b1;
    logic        sda_q     = 1'b1;
    logic        drive_low = 1'b0;

    assign sda_oe = drive_low;

    // Bit index 0 to 7 are data, 8 is the acknowledge slot
    always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q) begin
            // SDA edge with SCL high: falling is START, rising is STOP
            if (sda === 1'b0) begin
                mode    = S_ADDR;
                bit_idx = 0;
                rose    = 1'b0;
            end else begin
                mode = S_IDLE;
            end
            drive_low = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b0) begin
            // Sample on rising SCL
            rose = 1'b1;
            if (bit_idx < 8) begin
                if (mode == S_ADDR || mode == S_WR) begin
                    sr = {sr[6:0], sda};
                end
            end else if (mode == S_RD) begin
                nack = sda;
            end
        end else if (scl === 1'b0 && scl_q === 1'b1 && rose) begin
            // Change SDA only while SCL is low
            rose = 1'b0;
            if (bit_idx < 7) begin
                bit_idx = bit_idx + 1;
                if (mode == S_RD) begin
                    drive_low = !mem_q[7 - bit_idx];
                end
            end else if (bit_idx == 7) begin
                bit_idx   = 8;
                drive_low = 1'b0;
                case (mode)
                    S_ADDR: begin
                        if (sr[7:1] == SLAVE_ADDR) begin
                            drive_low = 1'b1;
                            mode      = sr[0] ? S_RD : S_WR;
                        end else begin
                            mode = S_SKIP;
                        end
                    end
                    S_WR: begin
                        mem_q     = sr;
                        drive_low = 1'b1;
                    end
                    default: ;
                endcase
            end else begin
                // Ack slot over
                bit_idx   = 0;
                drive_low = 1'b0;
                if (mode == S_RD) begin
                    if (nack) begin
                        mode = S_SKIP;
                    end else begin
                        drive_low = !mem_q[7];
                    end
                end
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// File: sim/tb_checker.sv
`timescale 1ns/1ps

module tb_checker
    import i2c_pkg::*;
#(
    parameter logic [6:0] SLAVE_ADDR = 7'h00
) (
    input  logic  clk_frame,
    input  logic  rst_n,
    input  logic  cmd_valid,
    input  logic  cmd_start,
    input  logic  cmd_stop,
    input  logic  cmd_read,
    input  byte_t tx_byte,
    input  logic  busy,
    input  logic  done,
    input  byte_t rx_byte,
    input  logic  ack_rx,
    input  logic  scl,
    input  logic  sda,
    output int    chk_cnt,
    output int    err_cnt
);

    // Slave view: selected for write, selected for read, register
    logic       sel_w;
    logic       sel_r;
    byte_t      reg_m;
    logic [8:0] exp_q;
    logic       rd_q;
    logic       pending;
    logic       start_ok;
    logic       stop_ok;
    logic       scl_q;
    logic       sda_q;
    logic       rst_q;

    // Expected {ack_rx, rx_byte} for one byte command
    function automatic logic [8:0] expect_result(input logic start, input logic rd,
                                                 input byte_t tx, input logic sw,
                                                 input logic sr, input byte_t reg_v);
        if (start) begin
            // Address byte, only the own address is acked
            expect_result = {tx[7:1] != SLAVE_ADDR, 8'h00};
        end else if (rd) begin
            // Unselected slave leaves SDA released
            expect_result = {1'b1, sr ? reg_v : 8'hff};
        end else begin
            expect_result = {!sw, 8'h00};
        end
    endfunction

    always @(posedge clk_frame) begin
        if (!rst_n) begin
            sel_w    = 1'b0;
            sel_r    = 1'b0;
            reg_m    = 8'h00;
            pending  = 1'b0;
            start_ok = 1'b0;
            stop_ok  = 1'b0;
            chk_cnt  = 0;
            err_cnt  = 0;
        end else begin
            //////////////////////////////////////////////////////////////////////////
            // Command accepted
            //////////////////////////////////////////////////////////////////////////
            if (cmd_valid && !busy) begin
                exp_q    = expect_result(cmd_start, cmd_read, tx_byte, sel_w, sel_r, reg_m);
                rd_q     = cmd_read;
                pending  = 1'b1;
                start_ok = cmd_start;
                stop_ok  = cmd_stop;
                if (cmd_start) begin
                    sel_w = (tx_byte[7:1] == SLAVE_ADDR) && !tx_byte[0];
                    sel_r = (tx_byte[7:1] == SLAVE_ADDR) && tx_byte[0];
                end else if (!cmd_read && sel_w) begin
                    reg_m = tx_byte;
                end
                if (cmd_stop) begin
                    sel_w = 1'b0;
                    sel_r = 1'b0;
                end
            end

            //////////////////////////////////////////////////////////////////////////
            // Result on done
            //////////////////////////////////////////////////////////////////////////
            if (done) begin
                chk_cnt = chk_cnt + 1;
                if (!pending) begin
                    $display("done pulsed with no command outstanding at %0t", $time);
                    err_cnt = err_cnt + 1;
                end else if (rd_q && rx_byte !== exp_q[7:0]) begin
                    $display("FAIL %0t rx_byte expected %02h got %02h",
                             $time, exp_q[7:0], rx_byte);
                    err_cnt = err_cnt + 1;
                end else if (!rd_q && ack_rx !== exp_q[8]) begin
                    $display("FAIL %0t ack_rx expected %b got %b", $time, exp_q[8], ack_rx);
                    err_cnt = err_cnt + 1;
                end
                pending = 1'b0;
            end

            // SDA may move under high SCL only as the requested START or STOP
            if (rst_q && scl && scl_q && sda !== sda_q) begin
                if (!sda && start_ok) begin
                    start_ok = 1'b0;
                end else if (sda && stop_ok) begin
                    stop_ok = 1'b0;
                end else begin
                    $display("protocol violation at %0t, SDA went %b while SCL was high",
                             $time, sda);
                    err_cnt = err_cnt + 1;
                end
            end
        end
        scl_q = scl;
        sda_q = sda;
        rst_q = rst_n;
    end

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_frame,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk_frame = 1'b0;
        forever #2 clk_frame = ~clk_frame;
    end

    // Reset held over 5 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk_frame);
        @(negedge clk_frame);
        rst_n = 1'b1;
    end

endmodule

// File: sim/tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master
    import i2c_pkg::*;
;

    localparam logic [6:0] SLAVE_ADDR    = 7'h3c;
    localparam int         DONE_TIMEOUT  = 200;
    localparam int         RESET_TIMEOUT = 50;

    logic  clk_frame;
    logic  rst_n;
    logic  cmd_valid;
    logic  cmd_start;
    logic  cmd_stop;
    logic  cmd_read;
    byte_t tx_byte;
    logic  ack_tx;
    logic  busy;
    logic  done;
    byte_t rx_byte;
    logic  ack_rx;
    logic  scl_oe;
    logic  sda_oe;
    logic  slave_sda_oe;
    logic  scl;
    logic  sda;
    int    chk_cnt;
    int    err_cnt;
    int    local_chk;
    int    local_err;
    int    seed;

    // Each line is a wired AND and stays high unless someone pulls it low
    assign scl = !scl_oe;
    assign sda = !(sda_oe || slave_sda_oe);

    tb_clock_gen u_clock_gen (.clk_frame(clk_frame), .rst_n(rst_n));

    i2c_master_top UUT (
        .clk_frame (clk_frame),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_start (cmd_start),
        .cmd_stop  (cmd_stop),
        .cmd_read  (cmd_read),
        .tx_byte   (tx_byte),
        .ack_tx    (ack_tx),
        .busy      (busy),
        .done      (done),
        .rx_byte   (rx_byte),
        .ack_rx    (ack_rx),
        .scl_oe    (scl_oe),
        .scl_in    (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    i2c_slave_model #(.SLAVE_ADDR(SLAVE_ADDR)) u_slave (
        .scl    (scl),
        .sda    (sda),
        .sda_oe (slave_sda_oe)
    );

    tb_checker #(.SLAVE_ADDR(SLAVE_ADDR)) u_checker (
        .clk_frame (clk_frame),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_start (cmd_start),
        .cmd_stop  (cmd_stop),
        .cmd_read  (cmd_read),
        .tx_byte   (tx_byte),
        .busy      (busy),
        .done      (done),
        .rx_byte   (rx_byte),
        .ack_rx    (ack_rx),
        .scl       (scl),
        .sda       (sda),
        .chk_cnt   (chk_cnt),
        .err_cnt   (err_cnt)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic int total_errors();
        return local_err + err_cnt;
    endfunction

    task automatic check_level(input string name, input logic exp, input logic act);
        local_chk = local_chk + 1;
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
            local_err = local_err + 1;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $finish;
    endtask

    // Reset counts as released only once it reads a clean high
    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk_frame);
            n = n + 1;
            if (n > RESET_TIMEOUT) begin
                abort_run("timeout, reset never released");
            end
        end
    endtask

    // Waits for done and one more edge so the checker has compared
    task automatic wait_done();
        int n;
        n = 0;
        while (!done) begin
            @(negedge clk_frame);
            n = n + 1;
            if (n > DONE_TIMEOUT) begin
                abort_run("timeout, done never came back");
            end
        end
        @(negedge clk_frame);
    endtask

    task automatic send_cmd(input logic start, input logic stop, input logic rd,
                            input byte_t data, input logic ack);
        @(negedge clk_frame);
        cmd_valid = 1'b1;
        cmd_start = start;
        cmd_stop  = stop;
        cmd_read  = rd;
        tx_byte   = data;
        ack_tx    = ack;
        @(negedge clk_frame);
        cmd_valid = 1'b0;
        wait_done();
    endtask

    task automatic check_released();
        check_level("scl", 1'b1, scl);
        check_level("sda", 1'b1, sda);
    endtask

    task automatic write_then_read(input byte_t data);
        send_cmd(1'b1, 1'b0, 1'b0, {SLAVE_ADDR, 1'b0}, 1'b0);
        send_cmd(1'b0, 1'b1, 1'b0, data, 1'b0);
        send_cmd(1'b1, 1'b0, 1'b0, {SLAVE_ADDR, 1'b1}, 1'b0);
        send_cmd(1'b0, 1'b1, 1'b1, 8'h00, 1'b1);
    endtask

    task automatic end_test(input string name, input int mark);
        if (total_errors() == mark) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            $display("[%0t] %s: %0d errors", $time, name, total_errors() - mark);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int         mark;
        logic [31:0] rnd;
        cmd_valid = 1'b0;
        cmd_start = 1'b0;
        cmd_stop  = 1'b0;
        cmd_read  = 1'b0;
        tx_byte   = 8'h00;
        ack_tx    = 1'b1;
        local_chk = 0;
        local_err = 0;
        seed      = 32'hefbe68af;
        wait_reset();

        mark = total_errors();
        @(negedge clk_frame);
        check_level("busy", 1'b0, busy);
        check_level("scl_oe", 1'b0, scl_oe);
        check_level("sda_oe", 1'b0, sda_oe);
        check_released();
        end_test("idle after reset", mark);

        mark = total_errors();
        send_cmd(1'b1, 1'b0, 1'b0, {SLAVE_ADDR, 1'b0}, 1'b0);
        send_cmd(1'b0, 1'b1, 1'b0, 8'ha5, 1'b0);
        check_released();
        end_test("addressed write", mark);

        mark = total_errors();
        send_cmd(1'b1, 1'b0, 1'b0, {SLAVE_ADDR, 1'b1}, 1'b0);
        send_cmd(1'b0, 1'b1, 1'b1, 8'h00, 1'b1);
        end_test("read back", mark);

        // Low address bit flipped so the register must survive
        mark = total_errors();
        send_cmd(1'b1, 1'b1, 1'b0, {SLAVE_ADDR ^ 7'h01, 1'b0}, 1'b0);
        check_released();
        send_cmd(1'b1, 1'b0, 1'b0, {SLAVE_ADDR, 1'b1}, 1'b0);
        send_cmd(1'b0, 1'b1, 1'b1, 8'h00, 1'b1);
        end_test("wrong address", mark);

        mark = total_errors();
        for (int i = 0; i < 20; i++) begin
            rnd = $random(seed);
            write_then_read(rnd[7:0]);
        end
        end_test("random loop", mark);

        $display("checks %0d, errors %0d", local_chk + chk_cnt, total_errors());
        if (total_errors() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: src/i2c_bit_ctrl.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Bus waveform per slot, one frame clock per phase
//
//             A       B       C       D
//   START    SCL=    SCL^    SCL^    SCL_
//            SDA^    SDA^    SDA_    SDA_
//   STOP     SCL_    SCL^    SCL^    SCL^
//            SDA_    SDA_    SDA^    SDA^
//   WRITE    SCL_    SCL^    SCL^    SCL_    SDA held at din
//   READ     SCL_    SCL^    SCL^    SCL_    SDA released
//
//   ^ released   _ pulled low   = kept as the previous slot left it
////////////////////////////////////////////////////////////////////////////

module i2c_bit_ctrl
    import i2c_pkg::*;
(
    input  logic     clk_frame,
    input  logic     rst_n,
    input  logic     bit_go,
    input  bit_cmd_t bit_cmd,
    input  logic     bit_din,
    input  logic     scl_in,
    input  logic     sda_in,
    output logic     bit_done,
    output logic     bit_dout,
    output logic     bit_busy,
    output logic     scl_oe,
    output logic     sda_oe
);

    frame_t   frame;
    frame_t   frame_nxt;
    bit_cmd_t cmd_q;
    bit_cmd_t cmd_nxt;
    logic     din_q;
    logic     din_nxt;
    logic     run_q;
    logic     run_nxt;
    logic     scl_oe_nxt;
    logic     sda_oe_nxt;
    logic     sda_smp;

    assign bit_busy = run_q;
    assign bit_done = run_q && (frame == PH_D);
    assign bit_dout = sda_smp;

    // Slot bookkeeping
    // A new slot may chain straight out of phase D
    always_comb begin
        run_nxt   = run_q;
        frame_nxt = frame;
        cmd_nxt   = cmd_q;
        din_nxt   = din_q;
        if (bit_go && (!run_q || bit_done)) begin
            run_nxt   = 1'b1;
            frame_nxt = PH_A;
            cmd_nxt   = bit_cmd;
            din_nxt   = bit_din;
        end else if (run_q) begin
            // Wraps back to PH_A after D
            run_nxt   = (frame != PH_D);
            frame_nxt = frame_t'(frame + 2'd1);
        end
    end

    // Line enables for the coming phase
    // Idle keeps the last levels, so SCL stays low between bytes
    always_comb begin
        scl_oe_nxt = scl_oe;
        sda_oe_nxt = sda_oe;
        if (run_nxt) begin
            case (cmd_nxt)
                BIT_START: begin
                    // Repeated START leaves SCL low in A while SDA lets go
                    scl_oe_nxt = (frame_nxt == PH_A) ? scl_oe : (frame_nxt == PH_D);
                    sda_oe_nxt = (frame_nxt inside {PH_C, PH_D});
                end
                BIT_STOP: begin
                    scl_oe_nxt = (frame_nxt == PH_A);
                    sda_oe_nxt = (frame_nxt inside {PH_A, PH_B});
                end
                BIT_WRITE: begin
                    scl_oe_nxt = (frame_nxt inside {PH_A, PH_D});
                    sda_oe_nxt = !din_nxt;
                end
                default: begin
                    // Read slot
                    scl_oe_nxt = (frame_nxt inside {PH_A, PH_D});
                    sda_oe_nxt = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_frame) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            frame  <= PH_A;
            scl_oe <= 1'b0;
            sda_oe <= 1'b0;
        end else begin
            run_q  <= run_nxt;
            frame  <= frame_nxt;
            scl_oe <= scl_oe_nxt;
            sda_oe <= sda_oe_nxt;
        end
    end

    // Latched slot and the SDA sample taken at the end of C
    always_ff @(posedge clk_frame) begin
        cmd_q <= cmd_nxt;
        din_q <= din_nxt;
        if (run_q && (frame == PH_C)) begin
            sda_smp <= sda_in;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus checks
    ////////////////////////////////////////////////////////////////////////////

    // Released SCL reads high unless something else stretches it
    a_no_stretch: assert property (@(posedge clk_frame) disable iff (!rst_n)
        !scl_oe |-> scl_in)
        else $error("SCL held low by another device while released");

    // SDA must hold from B into C in a data or ack slot
    a_sda_stable: assert property (@(posedge clk_frame) disable iff (!rst_n)
        run_q && (frame == PH_C) && (cmd_q inside {BIT_WRITE, BIT_READ})
            |-> $stable(sda_in))
        else $error("SDA moved while SCL high in a data slot");

endmodule

// File: src/i2c_byte_ctrl.sv
`timescale 1ns/1ps

module i2c_byte_ctrl
    import i2c_pkg::*;
(
    input  logic     clk_frame,
    input  logic     rst_n,
    input  logic     cmd_valid,
    input  logic     cmd_start,
    input  logic     cmd_stop,
    input  logic     cmd_read,
    input  byte_t    tx_byte,
    input  logic     ack_tx,
    input  logic     bit_done,
    input  logic     bit_dout,
    output logic     busy,
    output logic     done,
    output byte_t    rx_byte,
    output logic     ack_rx,
    output logic     bit_go,
    output bit_cmd_t bit_cmd,
    output logic     bit_din
);

    byte_state_t state;
    byte_state_t state_nxt;
    byte_state_t go_state;
    bit_cnt_t    bit_cnt;
    bit_cnt_t    cnt_nxt;
    byte_t       shreg;
    logic        read_q;
    logic        stop_q;
    logic        ack_tx_q;
    logic        launch;
    logic        step;
    logic        accept;

    assign busy    = (state != ST_IDLE);
    assign accept  = cmd_valid && !busy;
    assign step    = busy && bit_done;
    // Shift register ends the byte holding what was on SDA
    assign rx_byte = shreg;

    // Slot after the one now ending
    always_comb begin
        state_nxt = state;
        cnt_nxt   = bit_cnt;
        case (state)
            ST_START: state_nxt = ST_DATA;
            ST_DATA: begin
                if (bit_cnt == bit_cnt_t'(BITS_PER_BYTE - 1)) begin
                    state_nxt = ST_ACK;
                end else begin
                    cnt_nxt = bit_cnt + 1'b1;
                end
            end
            ST_ACK:  state_nxt = stop_q ? ST_STOP : ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    // First slot goes out on launch
    // Later ones chain off bit_done with no gap
    assign go_state = launch ? state : state_nxt;
    assign bit_go   = launch || (step && (state_nxt != ST_IDLE));

    always_comb begin
        bit_din = 1'b1;
        case (go_state)
            ST_START: bit_cmd = BIT_START;
            ST_DATA: begin
                // MSB first
                bit_cmd = read_q ? BIT_READ : BIT_WRITE;
                bit_din = shreg[BITS_PER_BYTE-1];
            end
            ST_ACK: begin
                // Master acks on reads, slave acks on writes
                bit_cmd = read_q ? BIT_WRITE : BIT_READ;
                bit_din = ack_tx_q;
            end
            default: bit_cmd = BIT_STOP;
        endcase
    end

    always_ff @(posedge clk_frame) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            launch  <= 1'b0;
            done    <= 1'b0;
        end else begin
            launch <= 1'b0;
            done   <= 1'b0;
            if (accept) begin
                state   <= cmd_start ? ST_START : ST_DATA;
                bit_cnt <= '0;
                launch  <= 1'b1;
            end else if (step) begin
                state   <= state_nxt;
                bit_cnt <= cnt_nxt;
                // Last slot over, busy drops on the same edge
                done    <= (state_nxt == ST_IDLE);
            end
        end
    end

    // Command fields and shift register
    // Each data or ack launch shifts out the MSB and pulls in the bit just read,
    // so after the ack launch all eight received bits sit in place
    always_ff @(posedge clk_frame) begin
        if (accept) begin
            shreg    <= tx_byte;
            read_q   <= cmd_read;
            stop_q   <= cmd_stop;
            ack_tx_q <= ack_tx;
        end else if (bit_go && (go_state inside {ST_DATA, ST_ACK})) begin
            shreg <= {shreg[BITS_PER_BYTE-2:0], bit_dout};
        end
        if (step && (state == ST_ACK) && !read_q) begin
            ack_rx <= bit_dout;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Handshake checks
    ////////////////////////////////////////////////////////////////////////////

    a_no_cmd_busy: assert property (@(posedge clk_frame) disable iff (!rst_n)
        cmd_valid |-> !busy)
        else $error("cmd_valid while busy, command dropped");

    // Done marks exactly the falling edge of busy
    a_done_busy: assert property (@(posedge clk_frame) disable iff (!rst_n)
        done |-> (!busy && $past(busy)))
        else $error("done outside the cycle busy falls");

    // Without bit_done the bit layer must have been quiet for a full slot
    a_go_spacing: assert property (@(posedge clk_frame) disable iff (!rst_n)
        (bit_go && !bit_done) |-> (!$past(bit_go) && !$past(bit_go, 2) && !$past(bit_go, 3)))
        else $error("bit_go while a bit slot was still running");

endmodule

// File: src/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top
    import i2c_pkg::*;
(
    input  logic  clk_frame,
    input  logic  rst_n,
    // Byte command
    input  logic  cmd_valid,
    input  logic  cmd_start,
    input  logic  cmd_stop,
    input  logic  cmd_read,
    input  byte_t tx_byte,
    input  logic  ack_tx,
    // Status
    output logic  busy,
    output logic  done,
    output byte_t rx_byte,
    output logic  ack_rx,
    // Open-drain pairs, high oe pulls the line low
    output logic  scl_oe,
    input  logic  scl_in,
    output logic  sda_oe,
    input  logic  sda_in
);

    // Byte layer to bit layer
    logic     bit_go;
    bit_cmd_t bit_cmd;
    logic     bit_din;
    logic     bit_done;
    logic     bit_dout;

    i2c_byte_ctrl u_byte_ctrl (
        .clk_frame (clk_frame),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_start (cmd_start),
        .cmd_stop  (cmd_stop),
        .cmd_read  (cmd_read),
        .tx_byte   (tx_byte),
        .ack_tx    (ack_tx),
        .bit_done  (bit_done),
        .bit_dout  (bit_dout),
        .busy      (busy),
        .done      (done),
        .rx_byte   (rx_byte),
        .ack_rx    (ack_rx),
        .bit_go    (bit_go),
        .bit_cmd   (bit_cmd),
        .bit_din   (bit_din)
    );

    // Slot activity is tracked by the byte layer itself
    i2c_bit_ctrl u_bit_ctrl (
        .clk_frame (clk_frame),
        .rst_n     (rst_n),
        .bit_go    (bit_go),
        .bit_cmd   (bit_cmd),
        .bit_din   (bit_din),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .bit_done  (bit_done),
        .bit_dout  (bit_dout),
        .bit_busy  (),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe)
    );

endmodule

// File: src/i2c_pkg.sv
package i2c_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////////////////////////////////////////

    // One data byte as it travels on SDA
    typedef logic [7:0] byte_t;

    // Data slots before the acknowledge slot
    localparam int BITS_PER_BYTE = 8;

    // Counts data slots within one byte
    typedef logic [3:0] bit_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bit layer encodings
    ////////////////////////////////////////////////////////////////////////////

    // Quarter-bit phases, one frame clock each
    typedef enum logic [1:0] {
        PH_A = 2'b00,
        PH_B = 2'b01,
        PH_C = 2'b10,
        PH_D = 2'b11
    } frame_t;

    // Operation carried out in one bit slot
    typedef enum logic [1:0] {
        BIT_START = 2'b00,
        BIT_STOP  = 2'b01,
        BIT_WRITE = 2'b10,
        BIT_READ  = 2'b11
    } bit_cmd_t;

    // Byte sequencer states, one per kind of slot
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_START = 3'd1,
        ST_DATA  = 3'd2,
        ST_ACK   = 3'd3,
        ST_STOP  = 3'd4
    } byte_state_t;

endpackage
